// ==== cmd_pkg.sv ====
// Operation and mode enums, request and result structs
`include "vadd_macros.svh"

package cmd_pkg;

	import lane_pkg::*;

	typedef enum logic {
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} op_e;

	// Split gives independent lanes, chained links all lane carries
	typedef enum logic {
		MODE_SPLIT = 1'b0,
		MODE_CHAIN = 1'b1
	} mode_e;

	typedef struct packed {
		lane_vec_t a;
		lane_vec_t b;
		op_e       op;
		mode_e     mode;
	} vadd_req_t;

	typedef struct packed {
		lane_vec_t  sum;
		lane_bits_t carry;
		lane_bits_t overflow;
		lane_bits_t zero;
	} vadd_res_t;

endpackage

// ==== han_carlson_tree.sv ====
// Han-Carlson carry prefix network for one 16-bit lane
`timescale 1ns/1ps
`include "vadd_macros.svh"

module han_carlson_tree (
	input  lane_pkg::lane_word_t p,
	input  lane_pkg::lane_word_t g,
	output lane_pkg::lane_word_t c
);

	import lane_pkg::*;

	// log2 of the lane width
	localparam int NUM_STAGES = 4;

	// Group generate and propagate after each stage, stage 0 is the input
	lane_word_t gs [0:NUM_STAGES];
	lane_word_t ps [0:NUM_STAGES];

	// Odd positions only, span doubles every stage
	always_comb begin
		int d;
		gs[0] = g;
		ps[0] = p;
		for (int s = 1; s <= NUM_STAGES; s++) begin
			d = 1 << (s - 1);
			gs[s] = gs[s-1];
			ps[s] = ps[s-1];
			for (int i = 1; i < `VADD_WIDTH; i += 2) begin
				if (i >= d) begin
					// Black cell, grey once the lower group reaches bit 0
					gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][i-d]);
					ps[s][i] = ps[s-1][i] & ps[s-1][i-d];
				end
			end
		end
	end

	// Extra grey stage fills the even positions from their odd neighbour
	always_comb begin
		c[0] = gs[NUM_STAGES][0];
		for (int i = 1; i < `VADD_WIDTH; i++) begin
			if (i % 2 == 1)
				c[i] = gs[NUM_STAGES][i];
			else
				c[i] = g[i] | (p[i] & gs[NUM_STAGES][i-1]);
		end
	end

endmodule

// ==== hc_adder_lane.sv ====
// One adder lane: carry-in select, pre-computation, prefix tree, sum and flags
`timescale 1ns/1ps
`include "vadd_macros.svh"

module hc_adder_lane (
	input  lane_pkg::lane_word_t a,
	input  lane_pkg::lane_word_t b,
	input  logic                 cin_base,
	input  logic                 chain_in,
	input  logic                 link_en,
	output lane_pkg::lane_word_t sum,
	output logic                 cout,
	output logic                 overflow
);

	import lane_pkg::*;

	logic                  cin;
	// Shifted by one so bit 0 holds the carry-in
	logic [`VADD_WIDTH:0]  p_ext;
	logic [`VADD_WIDTH:0]  g_ext;
	lane_word_t            carry;

	assign cin = link_en ? chain_in : cin_base;

	assign p_ext = {a ^ b, 1'b0};
	assign g_ext = {a & b, cin};

	han_carlson_tree prefix_tree (
		.p (p_ext[`VADD_WIDTH-1:0]),
		.g (g_ext[`VADD_WIDTH-1:0]),
		.c (carry)
	);

	// carry[k] is the carry into bit k
	assign sum = p_ext[`VADD_WIDTH:1] ^ carry;
	assign cout = g_ext[`VADD_WIDTH] | (p_ext[`VADD_WIDTH] & carry[`VADD_WIDTH-1]);
	assign overflow = cout ^ carry[`VADD_WIDTH-1];

endmodule

// ==== lane_pkg.sv ====
// Per-lane data types: lane word, packed lane vector and per-lane flag bits
`include "vadd_macros.svh"

package lane_pkg;

	// One lane operand or sum
	typedef logic [`VADD_WIDTH-1:0] lane_word_t;

	// All lane words side by side, lane 0 in the low bits
	typedef lane_word_t [`VADD_LANES-1:0] lane_vec_t;

	// One flag per lane
	typedef logic [`VADD_LANES-1:0] lane_bits_t;

endpackage

// ==== operand_issue.sv ====
// Request register with operand inversion, carry-in and lane link decode
`timescale 1ns/1ps
`include "vadd_macros.svh"

module operand_issue (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  cmd_pkg::vadd_req_t    req,
	output logic                  issue_valid,
	output lane_pkg::lane_vec_t   lane_a,
	output lane_pkg::lane_vec_t   lane_b,
	output lane_pkg::lane_bits_t  cin_base,
	output lane_pkg::lane_bits_t  link_en
);

	import lane_pkg::*;
	import cmd_pkg::*;

	logic       is_sub;
	logic       is_chain;
	lane_bits_t cin_next;
	lane_bits_t link_next;

	assign is_sub = (req.op == OP_SUB);
	assign is_chain = (req.mode == MODE_CHAIN);

	// Lane 0 never links, the upper lanes take the chain in chained mode
	always_comb begin
		for (int i = 0; i < `VADD_LANES; i++) begin
			cin_next[i] = is_sub & ((i == 0) | ~is_chain);
			link_next[i] = is_chain & (i != 0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			issue_valid <= 1'b0;
		else
			issue_valid <= in_valid;
	end

	// Subtract is a plus inverted b plus one
	always_ff @(posedge clk) begin
		if (in_valid) begin
			lane_a <= req.a;
			lane_b <= is_sub ? ~req.b : req.b;
			cin_base <= cin_next;
			link_en <= link_next;
		end
	end

endmodule

// ==== result_collect.sv ====
// Result register with per-lane zero flags and output strobe
`timescale 1ns/1ps
`include "vadd_macros.svh"

module result_collect (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  issue_valid,
	input  lane_pkg::lane_vec_t   lane_sum,
	input  lane_pkg::lane_bits_t  lane_cout,
	input  lane_pkg::lane_bits_t  lane_ovf,
	output logic                  out_valid,
	output cmd_pkg::vadd_res_t    res
);

	import lane_pkg::*;

	lane_bits_t zero_flags;

	// Zero is per lane even in chained mode
	always_comb begin
		for (int i = 0; i < `VADD_LANES; i++) begin
			zero_flags[i] = (lane_sum[i] == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			res.sum <= lane_sum;
			res.carry <= lane_cout;
			res.overflow <= lane_ovf;
			res.zero <= zero_flags;
		end
	end

endmodule

// ==== src.f ====
+incdir+.
lane_pkg.sv
cmd_pkg.sv
han_carlson_tree.sv
hc_adder_lane.sv
operand_issue.sv
result_collect.sv
vector_adder_top.sv
vector_adder_sva.sv
vector_adder_tb.sv

// ==== vadd_macros.svh ====
// Lane count, lane width and test length macros for the vector adder
`ifndef VADD_MACROS_SVH
`define VADD_MACROS_SVH

// Number of adder lanes
`define VADD_LANES 4

// Bits per lane, the prefix tree only supports 16
`define VADD_WIDTH 16

// Random requests per test run
`define VADD_NUM_REQ 200

`endif

// ==== vector_adder_sva.sv ====
// Bound assertions on output strobe timing, reset behavior and result validity
`timescale 1ns/1ps

module vector_adder_sva (
	input logic               clk,
	input logic               rst,
	input logic               in_valid,
	input logic               out_valid,
	input cmd_pkg::vadd_res_t res
);

	// Number of assertion failures so far
	int fail_count = 0;

	// Two-cycle latency, a request taken under reset is dropped
	property latency_two_cycles;
		@(posedge clk) disable iff (rst)
		out_valid == ($past(in_valid, 2) && !$past(rst, 1) && !$past(rst, 2));
	endproperty

	a_latency: assert property (latency_two_cycles)
		else begin
			$error("out_valid does not follow in_valid by two cycles");
			fail_count++;
		end

	a_reset_low: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			$error("out_valid high after a reset cycle");
			fail_count++;
		end

	a_res_known: assert property (
		@(posedge clk) disable iff (rst) out_valid |-> !$isunknown(res))
		else begin
			$error("res has unknown bits while out_valid is high");
			fail_count++;
		end

endmodule

// ==== vector_adder_tb.sv ====
// Testbench for the vector adder: random stimulus, reference model, compare tasks and report
`timescale 1ns/1ps
`include "vadd_macros.svh"

module vector_adder_tb;

	import lane_pkg::*;
	import cmd_pkg::*;

	// Back-to-back test can take up to four cycles per request
	localparam int TIMEOUT_CYCLES = 4 * `VADD_NUM_REQ + 100;

	logic      clk;
	logic      rst;
	logic      in_valid;
	vadd_req_t req;
	logic      out_valid;
	vadd_res_t res;

	vadd_res_t exp_q [$];
	int        exp_cyc_q [$];
	int        cyc;
	int        test_start;
	int        test_num;
	int        test_err_base;
	int        errors;
	int        failed_tests;
	int        results_seen;

	vector_adder_top vector_adder_top_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.res       (res)
	);

	bind vector_adder_top vector_adder_sva sva_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.res       (res)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc - test_start > TIMEOUT_CYCLES) begin
			$display("Timeout: test %0d did not finish within %0d cycles", test_num,
				TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Failures flagged by the bound assertions
	function automatic int assertion_failures();
		return vector_adder_top_inst.sva_inst.fail_count;
	endfunction

	// Reference: subtract is a plus inverted b plus one
	function automatic vadd_res_t model(input vadd_req_t r);
		vadd_res_t   e;
		lane_vec_t   b_eff;
		logic        cin;
		logic [16:0] lane_sum;
		logic [64:0] wide;
		logic [64:0] carry_into;
		cin = (r.op == OP_SUB);
		b_eff = cin ? ~r.b : r.b;
		if (r.mode == MODE_SPLIT) begin
			for (int i = 0; i < `VADD_LANES; i++) begin
				lane_sum = {1'b0, r.a[i]} + {1'b0, b_eff[i]} + cin;
				e.sum[i] = lane_sum[15:0];
				e.carry[i] = lane_sum[16];
				// Operands of equal sign giving a sum of the other sign
				e.overflow[i] = (r.a[i][15] == b_eff[i][15]) && (lane_sum[15] != r.a[i][15]);
			end
		end else begin
			wide = {1'b0, r.a} + {1'b0, b_eff} + cin;
			// Carry into each bit position of the 64-bit add
			carry_into = wide ^ {1'b0, r.a} ^ {1'b0, b_eff};
			e.sum = wide[63:0];
			for (int i = 0; i < `VADD_LANES; i++) begin
				e.carry[i] = carry_into[`VADD_WIDTH*(i+1)];
				e.overflow[i] = (r.a[i][15] == b_eff[i][15]) && (e.sum[i][15] != r.a[i][15]);
			end
		end
		for (int i = 0; i < `VADD_LANES; i++)
			e.zero[i] = (e.sum[i] == '0);
		return e;
	endfunction

	function automatic vadd_req_t make_req(input lane_vec_t a, input lane_vec_t b,
			input op_e op, input mode_e mode);
		vadd_req_t r;
		r.a = a;
		r.b = b;
		r.op = op;
		r.mode = mode;
		return r;
	endfunction

	// Some lanes get equal, negated or all-ones operands to reach zero and carry cases
	function automatic vadd_req_t rand_req(input op_e op, input mode_e mode);
		vadd_req_t r;
		r = make_req({$urandom, $urandom}, {$urandom, $urandom}, op, mode);
		for (int i = 0; i < `VADD_LANES; i++) begin
			case ($urandom % 8)
				0: r.b[i] = r.a[i];
				1: r.a[i] = 16'hFFFF;
				2: r.b[i] = 16'h0 - r.a[i];
				default: ;
			endcase
		end
		return r;
	endfunction

	task automatic check_sum(input string name, input lane_vec_t got, input lane_vec_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
		end
	endtask

	task automatic check_flags(input string name, input lane_bits_t got,
			input lane_bits_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
		end
	endtask

	// Outputs change on the rising edge, so they are read on the falling one
	always @(negedge clk) begin
		vadd_res_t exp_res;
		int        exp_cyc;
		if (out_valid === 1'b1) begin
			results_seen++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_valid high at cycle %0d with no request pending", cyc);
			end else begin
				exp_res = exp_q.pop_front();
				exp_cyc = exp_cyc_q.pop_front();
				if (cyc != exp_cyc) begin
					errors++;
					$display("Result came at cycle %0d instead of cycle %0d", cyc, exp_cyc);
				end
				check_sum("res.sum", res.sum, exp_res.sum);
				check_flags("res.carry", res.carry, exp_res.carry);
				check_flags("res.overflow", res.overflow, exp_res.overflow);
				check_flags("res.zero", res.zero, exp_res.zero);
			end
		end
	end

	task automatic send(input vadd_req_t r);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		req = r;
		exp_q.push_back(model(r));
		exp_cyc_q.push_back(cyc + 2);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic begin_test();
		test_num++;
		test_start = cyc;
		test_err_base = errors + assertion_failures();
	endtask

	task automatic end_test(input string name);
		int test_errs;
		idle(1);
		while (exp_q.size() != 0)
			@(posedge clk);
		idle(3);
		test_errs = errors + assertion_failures() - test_err_base;
		if (test_errs != 0)
			failed_tests++;
		$display("Test %0d %s: %s, %0d errors", test_num, name,
			(test_errs == 0) ? "ok" : "failed", test_errs);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		req = '0;
		cyc = 0;
		test_start = 0;
		test_num = 0;
		test_err_base = 0;
		errors = 0;
		failed_tests = 0;
		results_seen = 0;
		void'($urandom(21));
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		begin_test();
		repeat (`VADD_NUM_REQ) send(rand_req(OP_ADD, MODE_SPLIT));
		end_test("split add");

		begin_test();
		repeat (`VADD_NUM_REQ) send(rand_req(OP_SUB, MODE_SPLIT));
		end_test("split subtract");

		// All ones plus one carries through every lane
		begin_test();
		send(make_req({4{16'hFFFF}}, 64'd1, OP_ADD, MODE_CHAIN));
		send(make_req('0, 64'd1, OP_SUB, MODE_CHAIN));
		send(make_req({48'h0, 16'hFFFF}, 64'd1, OP_ADD, MODE_CHAIN));
		send(make_req({16'h7FFF, {3{16'hFFFF}}}, 64'd1, OP_ADD, MODE_CHAIN));
		repeat (`VADD_NUM_REQ) send(rand_req(($urandom % 2) ? OP_SUB : OP_ADD, MODE_CHAIN));
		end_test("chained");

		begin_test();
		repeat (`VADD_NUM_REQ) begin
			send(rand_req(($urandom % 2) ? OP_SUB : OP_ADD,
				($urandom % 2) ? MODE_CHAIN : MODE_SPLIT));
			if ($urandom % 4 == 0)
				idle($urandom % 3 + 1);
		end
		end_test("back to back");

		// Requests under reset must vanish, then one real request
		begin_test();
		rst = 1'b1;
		repeat (10) begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			req = rand_req(OP_ADD, MODE_SPLIT);
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		in_valid = 1'b0;
		idle(10);
		send(rand_req(OP_SUB, MODE_CHAIN));
		end_test("reset");

		errors += assertion_failures();
		$display("Tests run %0d, tests failed %0d, results %0d, errors %0d", test_num,
			failed_tests, results_seen, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== vector_adder_top.sv ====
// Vector adder top: issue stage, Han-Carlson lanes and result collector
`timescale 1ns/1ps
`include "vadd_macros.svh"

module vector_adder_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  cmd_pkg::vadd_req_t  req,
	output logic                out_valid,
	output cmd_pkg::vadd_res_t  res
);

	import lane_pkg::*;

	logic       issue_valid;
	lane_vec_t  lane_a;
	lane_vec_t  lane_b;
	lane_vec_t  lane_sum;
	lane_bits_t cin_base;
	lane_bits_t link_en;
	lane_bits_t lane_cout;
	lane_bits_t lane_ovf;
	lane_bits_t chain_in;

	operand_issue issue_inst (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.req         (req),
		.issue_valid (issue_valid),
		.lane_a      (lane_a),
		.lane_b      (lane_b),
		.cin_base    (cin_base),
		.link_en     (link_en)
	);

	// Carry ripples lane to lane within the cycle, lane 0 sees zero
	assign chain_in = {lane_cout[`VADD_LANES-2:0], 1'b0};

	for (genvar i = 0; i < `VADD_LANES; i++) begin : g_lane
		hc_adder_lane lane_inst (
			.a        (lane_a[i]),
			.b        (lane_b[i]),
			.cin_base (cin_base[i]),
			.chain_in (chain_in[i]),
			.link_en  (link_en[i]),
			.sum      (lane_sum[i]),
			.cout     (lane_cout[i]),
			.overflow (lane_ovf[i])
		);
	end

	result_collect collect_inst (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.lane_sum    (lane_sum),
		.lane_cout   (lane_cout),
		.lane_ovf    (lane_ovf),
		.out_valid   (out_valid),
		.res         (res)
	);

endmodule
